// ==== floor_controller.f ====
+incdir+source
source/elevator_pkg.sv
source/button_conditioner.sv
source/floor_request_cell.sv
source/dispatch_controller.sv
source/floor_controller_top.sv
tb/floor_controller_tb.sv

// ==== source/button_conditioner.sv ====
//////////////////////////////////////////////////
// Button synchronizer and per-floor strobe decode
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "elevator_macros.svh"

module button_conditioner (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    input  logic                      emergency_button,
    input  logic                      power_switch,
    input  logic                      idle_at_floor,
    input  elevator_pkg::floor_t      current_floor,
    input  elevator_pkg::floor_t      arrival_floor,
    input  logic                      arrival,
    output elevator_pkg::floor_mask_t call_set,
    output elevator_pkg::floor_mask_t panel_set,
    output elevator_pkg::floor_mask_t arrival_clear,
    output logic                      door_open_sync,
    output logic                      door_close_sync,
    output logic                      dispatch_enable
);
    import elevator_pkg::*;

    // Both button masks plus door, emergency and power
    localparam int SYNC_WIDTH = 2 * `FLOOR_COUNT + 4;

    logic [SYNC_WIDTH-1:0] sync_stage1;
    logic [SYNC_WIDTH-1:0] sync_stage2;
    floor_mask_t           call_sync;
    floor_mask_t           panel_sync;
    floor_mask_t           floor_here;
    floor_mask_t           set_allow;
    logic                  emergency_sync;
    logic                  power_sync;

    //////////////////////////////////////////////////
    // Two-stage synchronizer
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sync_stage1 <= '0;
            sync_stage2 <= '0;
        end else begin
            sync_stage1 <= {floor_call_buttons, panel_buttons, door_open_button,
                            door_close_button, emergency_button, power_switch};
            sync_stage2 <= sync_stage1;
        end
    end

    assign {call_sync, panel_sync, door_open_sync, door_close_sync,
            emergency_sync, power_sync} = sync_stage2;

    assign dispatch_enable = power_sync && !emergency_sync;

    //////////////////////////////////////////////////
    // Strobe decode
    //////////////////////////////////////////////////
    always_comb begin
        floor_here    = '0;
        arrival_clear = '0;
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            // A parked car swallows presses at its own floor
            floor_here[i]    = idle_at_floor && (current_floor == floor_t'(i));
            arrival_clear[i] = arrival && (arrival_floor == floor_t'(i));
        end
    end

    assign set_allow = dispatch_enable ? ~floor_here : '0;
    assign call_set  = call_sync & set_allow;
    assign panel_set = panel_sync & set_allow;

endmodule

// ==== source/dispatch_controller.sv ====
//////////////////////////////////////////////////
// Direction-priority target selection
// Four-phase req/ack FSM toward the car drive
// Door open and close permits
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "elevator_macros.svh"

module dispatch_controller (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t pending_above,
    input  elevator_pkg::floor_mask_t pending_below,
    input  logic                      dispatch_enable,
    input  logic                      door_open_sync,
    input  logic                      door_close_sync,
    input  logic                      power_switch,
    input  logic                      move_ack,
    output logic                      move_req,
    output logic                      direction_up,
    output logic                      arrival,
    output logic                      idle_at_floor,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed,
    output elevator_pkg::floor_t      target_floor
);
    import elevator_pkg::*;

    dispatch_state_t state;
    floor_t          nearest_above;
    floor_t          nearest_below;
    floor_t          next_target;
    logic            found_above;
    logic            found_below;
    logic            next_up;
    logic            launch;
    logic            door_window;

    //////////////////////////////////////////////////
    // Nearest pending floor on each side
    //////////////////////////////////////////////////
    always_comb begin
        nearest_above = '0;
        nearest_below = '0;
        // Lowest index above the car is the closest one
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (pending_above[i]) begin
                nearest_above = floor_t'(i);
            end
        end
        // Highest index below the car is the closest one
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (pending_below[i]) begin
                nearest_below = floor_t'(i);
            end
        end
    end

    assign found_above = |pending_above;
    assign found_below = |pending_below;

    // Keep going the same way while there is work ahead, else reverse
    always_comb begin
        if (direction_up) begin
            if (found_above) begin
                next_target = nearest_above;
                next_up     = 1'b1;
            end else begin
                next_target = nearest_below;
                next_up     = 1'b0;
            end
        end else begin
            if (found_below) begin
                next_target = nearest_below;
                next_up     = 1'b0;
            end else begin
                next_target = nearest_above;
                next_up     = 1'b1;
            end
        end
    end

    assign launch = (state == STATE_IDLE) && dispatch_enable && (found_above || found_below);

    //////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= STATE_IDLE;
            move_req     <= 1'b0;
            target_floor <= '0;
            direction_up <= 1'b1;
        end else begin
            case (state)
                STATE_IDLE: begin
                    if (launch) begin
                        target_floor <= next_target;
                        direction_up <= next_up;
                        move_req     <= 1'b1;
                        state        <= STATE_REQUEST;
                    end
                end
                STATE_REQUEST: begin
                    // Target and direction hold until the car answers
                    if (move_ack) begin
                        move_req <= 1'b0;
                        state    <= STATE_RELEASE;
                    end
                end
                STATE_RELEASE: begin
                    if (!move_ack) begin
                        state <= STATE_IDLE;
                    end
                end
                default: begin
                    move_req <= 1'b0;
                    state    <= STATE_IDLE;
                end
            endcase
        end
    end

    // Clears the target floor's lights on the ack edge
    assign arrival = (state == STATE_REQUEST) && move_ack;

    // Car parked, either idle or finishing the handshake at its target
    assign idle_at_floor = (state != STATE_REQUEST);

    //////////////////////////////////////////////////
    // Door permits
    //////////////////////////////////////////////////
    assign door_window = (state == STATE_IDLE) && !launch && power_switch;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_window && door_open_sync;
            door_close_allowed <= door_window && door_close_sync;
        end
    end

endmodule

// ==== source/elevator_macros.svh ====
//////////////////////////////////////////////////
// Floor count and floor index width for the car
//////////////////////////////////////////////////

`ifndef ELEVATOR_MACROS_SVH
`define ELEVATOR_MACROS_SVH

// Floors 1 through 11 map to indices 0 through 10
`define FLOOR_COUNT 11

// Wide enough for index 10
`define FLOOR_WIDTH 4

`endif

// ==== source/elevator_pkg.sv ====
//////////////////////////////////////////////////
// Shared types for the floor request controller
// Floor index, per-floor mask, dispatch states
//////////////////////////////////////////////////

`include "elevator_macros.svh"

package elevator_pkg;

    // Floor index, 0 is floor 1
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor for buttons, lights and strobes
    typedef logic [`FLOOR_COUNT-1:0] floor_mask_t;

    // Dispatch handshake states
    typedef enum logic [1:0] {
        STATE_IDLE    = 2'd0,
        STATE_REQUEST = 2'd1,
        STATE_RELEASE = 2'd2
    } dispatch_state_t;

endpackage

// ==== source/floor_controller_top.sv ====
//////////////////////////////////////////////////
// Floor request controller top level
// Conditioner, per-floor request cells, dispatcher
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "elevator_macros.svh"

module floor_controller_top (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    input  logic                      emergency_button,
    input  logic                      power_switch,
    input  elevator_pkg::floor_t      current_floor,
    input  logic                      move_ack,
    output logic                      move_req,
    output elevator_pkg::floor_t      target_floor,
    output logic                      direction_up,
    output elevator_pkg::floor_mask_t call_lights,
    output elevator_pkg::floor_mask_t panel_lights,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);
    import elevator_pkg::*;

    floor_mask_t call_set;
    floor_mask_t panel_set;
    floor_mask_t arrival_clear;
    floor_mask_t pending_above;
    floor_mask_t pending_below;
    logic        door_open_sync;
    logic        door_close_sync;
    logic        dispatch_enable;
    logic        idle_at_floor;
    logic        arrival;

    button_conditioner i_button_conditioner (
        .clock              (clock),
        .reset_n            (reset_n),
        .floor_call_buttons (floor_call_buttons),
        .panel_buttons      (panel_buttons),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .emergency_button   (emergency_button),
        .power_switch       (power_switch),
        .idle_at_floor      (idle_at_floor),
        .current_floor      (current_floor),
        .arrival_floor      (target_floor),
        .arrival            (arrival),
        .call_set           (call_set),
        .panel_set          (panel_set),
        .arrival_clear      (arrival_clear),
        .door_open_sync     (door_open_sync),
        .door_close_sync    (door_close_sync),
        .dispatch_enable    (dispatch_enable)
    );

    // One request cell per floor
    for (genvar i = 0; i < `FLOOR_COUNT; i++) begin : g_floor
        floor_request_cell #(
            .FLOOR_INDEX (i)
        ) i_floor_request_cell (
            .clock         (clock),
            .reset_n       (reset_n),
            .call_set      (call_set[i]),
            .panel_set     (panel_set[i]),
            .arrival_clear (arrival_clear[i]),
            .current_floor (current_floor),
            .call_light    (call_lights[i]),
            .panel_light   (panel_lights[i]),
            // Already folded into above and below
            .pending       (),
            .above         (pending_above[i]),
            .below         (pending_below[i])
        );
    end

    dispatch_controller i_dispatch_controller (
        .clock              (clock),
        .reset_n            (reset_n),
        .pending_above      (pending_above),
        .pending_below      (pending_below),
        .dispatch_enable    (dispatch_enable),
        .door_open_sync     (door_open_sync),
        .door_close_sync    (door_close_sync),
        .power_switch       (power_switch),
        .move_ack           (move_ack),
        .move_req           (move_req),
        .direction_up       (direction_up),
        .arrival            (arrival),
        .idle_at_floor      (idle_at_floor),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed),
        .target_floor       (target_floor)
    );

endmodule

// ==== source/floor_request_cell.sv ====
//////////////////////////////////////////////////
// One floor's call and panel lights
// Reports whether its request is above or below the car
//////////////////////////////////////////////////

`timescale 1ns/1ps

module floor_request_cell #(
    parameter int FLOOR_INDEX = 0
) (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 call_set,
    input  logic                 panel_set,
    input  logic                 arrival_clear,
    input  elevator_pkg::floor_t current_floor,
    output logic                 call_light,
    output logic                 panel_light,
    output logic                 pending,
    output logic                 above,
    output logic                 below
);
    import elevator_pkg::*;

    localparam floor_t OWN_FLOOR = floor_t'(FLOOR_INDEX);

    // Arrival clear wins over a press on the same edge
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_light  <= 1'b0;
            panel_light <= 1'b0;
        end else if (arrival_clear) begin
            call_light  <= 1'b0;
            panel_light <= 1'b0;
        end else begin
            if (call_set) begin
                call_light <= 1'b1;
            end
            if (panel_set) begin
                panel_light <= 1'b1;
            end
        end
    end

    assign pending = call_light || panel_light;

    // Position of this floor relative to the car
    assign above = pending && (OWN_FLOOR > current_floor);
    assign below = pending && (OWN_FLOOR < current_floor);

endmodule

// ==== tb/floor_controller_tb.sv ====
//////////////////////////////////////////////////
// Testbench for the floor request controller
// Car model, vector steps, random dispatch runs
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "elevator_macros.svh"

module floor_controller_tb;
    import elevator_pkg::*;

    localparam int    VEC_COLS   = 14;
    localparam int    VEC_MAX    = 64;
    localparam int    RAND_TESTS = 4;
    localparam int    MARGIN     = 200;
    localparam string VEC_FILE   = "tb/floor_controller_vectors.txt";

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_button;
    logic        door_close_button;
    logic        emergency_button;
    logic        power_switch;
    floor_t      current_floor;
    logic        move_ack;
    logic        move_req;
    floor_t      target_floor;
    logic        direction_up;
    floor_mask_t call_lights;
    floor_mask_t panel_lights;
    logic        door_open_allowed;
    logic        door_close_allowed;

    logic [15:0] vec_mem [0:VEC_COLS*VEC_MAX-1];
    int          vec_count;
    int          car_delay;
    int          cycles;
    int          cycle_limit;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_start_errors;
    logic        prev_req;
    floor_t      prev_target;
    logic        last_trip_up;
    logic [31:0] rand_state;

    floor_controller_top i_floor_controller_top (.*);

    always #5 clock = ~clock;

    // Run limit guard
    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles without finishing", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Car drive model
    //////////////////////////////////////////////////
    always begin
        wait (move_req === 1'b1);
        repeat (car_delay) @(negedge clock);
        last_trip_up  <= (target_floor > current_floor);
        current_floor <= target_floor;
        @(negedge clock);
        move_ack <= 1'b1;
        wait (move_req === 1'b0);
        // A slow car also lets go of the ack late
        repeat (car_delay) @(negedge clock);
        move_ack <= 1'b0;
    end

    // Four-phase ordering watch
    always @(negedge clock) begin
        if (reset_n) begin
            if (move_req && !prev_req && move_ack) begin
                $display("At %0d ns move_req rose while move_ack was still high", $time);
                errors++;
            end
            if (move_req && prev_req && target_floor !== prev_target) begin
                $display("At %0d ns target_floor changed while move_req was high", $time);
                errors++;
            end
            if (!move_req && prev_req && !move_ack) begin
                $display("At %0d ns move_req dropped before move_ack arrived", $time);
                errors++;
            end
        end
        prev_req    = move_req;
        prev_target = target_floor;
    end

    //////////////////////////////////////////////////
    // Compare tasks and helpers
    //////////////////////////////////////////////////
    task automatic check_mask(input string name, input floor_mask_t act, input floor_mask_t exp);
        if (act !== exp) begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic check_floor(input string name, input floor_t act, input floor_t exp);
        if (act !== exp) begin
            $display("ERROR at %0d ns: %s is %0d, expected %0d", $time, name, act, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("ERROR at %0d ns: %s is %b, expected %b", $time, name, act, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Returns direction in the top bit, target floor below it
    function automatic logic [4:0] predict_target(input floor_mask_t lit, input int cf,
                                                   input logic up);
        int above_idx;
        int below_idx;
        above_idx = -1;
        below_idx = -1;
        for (int d = `FLOOR_COUNT - 1; d >= 1; d--) begin
            if (cf + d < `FLOOR_COUNT) begin
                if (lit[cf + d]) above_idx = cf + d;
            end
            if (cf - d >= 0) begin
                if (lit[cf - d]) below_idx = cf - d;
            end
        end
        if ((up && above_idx >= 0) || (!up && below_idx < 0)) begin
            return {1'b1, floor_t'(above_idx)};
        end
        return {1'b0, floor_t'(below_idx)};
    endfunction

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_start_errors) begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     errors - test_start_errors);
        end else begin
            $display("Test %0d %s: ok", tests_run, name);
        end
        test_start_errors = errors;
    endtask

    // Presses last one cycle, levels hold for the whole step
    task automatic press_and_settle(input floor_mask_t calls, input floor_mask_t panels);
        floor_call_buttons = calls;
        panel_buttons      = panels;
        @(negedge clock);
        floor_call_buttons = '0;
        panel_buttons      = '0;
        repeat (3) @(negedge clock);
    endtask

    task automatic wait_quiet();
        while (!(move_req == 1'b0 && move_ack == 1'b0 &&
                 ((call_lights | panel_lights) == '0 || !power_switch || emergency_button))) begin
            @(negedge clock);
        end
    endtask

    //////////////////////////////////////////////////
    // Vector steps
    //////////////////////////////////////////////////
    task automatic run_vector(input int n);
        int b;
        b = n * VEC_COLS;
        door_open_button  = vec_mem[b + 2][0];
        door_close_button = vec_mem[b + 3][0];
        emergency_button  = vec_mem[b + 4][0];
        power_switch      = vec_mem[b + 5][0];
        car_delay         = vec_mem[b + 7];
        press_and_settle(floor_mask_t'(vec_mem[b]), floor_mask_t'(vec_mem[b + 1]));
        check_mask("call_lights", call_lights, floor_mask_t'(vec_mem[b + 8]));
        check_mask("panel_lights", panel_lights, floor_mask_t'(vec_mem[b + 9]));
        check_floor("target_floor", target_floor, floor_t'(vec_mem[b + 10]));
        check_bit("direction_up", direction_up, vec_mem[b + 11][0]);
        check_bit("door_open_allowed", door_open_allowed, vec_mem[b + 12][0]);
        check_bit("door_close_allowed", door_close_allowed, vec_mem[b + 13][0]);
        // Emergency raised while the request is still out
        if (vec_mem[b + 6][0]) begin
            emergency_button = 1'b1;
        end
        wait_quiet();
        if (!power_switch || emergency_button) begin
            repeat (6) @(negedge clock);
            check_bit("move_req", move_req, 1'b0);
        end
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        finish_test($sformatf("vector step %0d", n));
    endtask

    //////////////////////////////////////////////////
    // Random presses served in direction-priority order
    //////////////////////////////////////////////////
    task automatic run_random(input int n);
        floor_mask_t calls;
        floor_mask_t panels;
        floor_mask_t remaining;
        logic [4:0]  pick;
        int          cf;
        logic        up;
        cf         = current_floor;
        up         = last_trip_up;
        car_delay  = 3;
        rand_state = next_random(rand_state);
        calls      = floor_mask_t'(rand_state) & ~(floor_mask_t'(1) << cf);
        rand_state = next_random(rand_state);
        panels     = floor_mask_t'(rand_state >> 8) & ~(floor_mask_t'(1) << cf);
        if ((calls | panels) == '0) begin
            calls = floor_mask_t'(1) << ((cf + 5) % `FLOOR_COUNT);
        end
        remaining = calls | panels;
        press_and_settle(calls, panels);
        check_mask("call_lights", call_lights, calls);
        check_mask("panel_lights", panel_lights, panels);
        while (remaining != '0) begin
            while (move_req !== 1'b1) @(negedge clock);
            pick = predict_target(remaining, cf, up);
            check_floor("target_floor", target_floor, pick[3:0]);
            check_bit("direction_up", direction_up, pick[4]);
            cf = pick[3:0];
            up = pick[4];
            remaining[cf] = 1'b0;
            while (move_req !== 1'b0) @(negedge clock);
            // Only the served floor went dark at the ack
            check_mask("call_lights", call_lights, calls & remaining);
            check_mask("panel_lights", panel_lights, panels & remaining);
        end
        wait_quiet();
        // Both door permits follow their buttons while the car is parked
        door_open_button  = 1'b1;
        door_close_button = 1'b1;
        repeat (4) @(negedge clock);
        check_bit("door_open_allowed", door_open_allowed, 1'b1);
        check_bit("door_close_allowed", door_close_allowed, 1'b1);
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        repeat (4) @(negedge clock);
        check_bit("door_open_allowed", door_open_allowed, 1'b0);
        check_bit("door_close_allowed", door_close_allowed, 1'b0);
        finish_test($sformatf("random dispatch %0d", n));
    endtask

    initial begin
        clock              = 1'b0;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_button   = 1'b0;
        door_close_button  = 1'b0;
        emergency_button   = 1'b0;
        power_switch       = 1'b1;
        current_floor      = '0;
        move_ack           = 1'b0;
        car_delay          = 3;
        cycles             = 0;
        errors             = 0;
        tests_run          = 0;
        tests_failed       = 0;
        test_start_errors  = 0;
        prev_req           = 1'b0;
        prev_target        = '0;
        last_trip_up       = 1'b1;
        rand_state         = 32'h3f0b;
        for (int i = 0; i < VEC_COLS * VEC_MAX; i++) vec_mem[i] = 16'hffff;
        $readmemh(VEC_FILE, vec_mem);
        vec_count   = 0;
        cycle_limit = 16 + MARGIN + RAND_TESTS * (`FLOOR_COUNT * 16 + 8);
        while (vec_count < VEC_MAX && vec_mem[vec_count * VEC_COLS] != 16'hffff) begin
            cycle_limit += 12 + `FLOOR_COUNT * (vec_mem[vec_count * VEC_COLS + 7] + 10);
            vec_count++;
        end
        repeat (16) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        check_mask("call_lights", call_lights, '0);
        check_mask("panel_lights", panel_lights, '0);
        check_bit("move_req", move_req, 1'b0);
        check_bit("direction_up", direction_up, 1'b1);
        check_floor("target_floor", target_floor, '0);
        check_bit("door_open_allowed", door_open_allowed, 1'b0);
        check_bit("door_close_allowed", door_close_allowed, 1'b0);
        finish_test("reset state");
        if (vec_count == 0) begin
            $display("No test vectors could be read from %s", VEC_FILE);
            errors++;
        end
        for (int i = 0; i < vec_count; i++) run_vector(i);
        for (int i = 0; i < RAND_TESTS; i++) run_random(i);
        $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb/floor_controller_vectors.txt ====
// call panel door_open door_close emergency power late_emergency car_delay
// expect: call_lights panel_lights target_floor direction_up door_open door_close
// Single press of floor 5 from floor 1
010 000 0 0 0 1 0 3  010 000 4 1 0 0
// Press at the parked car's own floor is swallowed
010 000 0 0 0 1 0 3  000 000 4 1 0 0
// Three floors lit, nearest above first, then reversal
104 040 0 0 0 1 0 3  104 040 6 1 0 0
// Heading down, nearest below before the top floor
001 400 0 0 0 1 0 3  001 400 0 0 0 0
// Door open while idle with power on
000 000 1 0 0 1 0 3  000 000 a 1 1 0
// Power off blocks presses and the close permit
002 000 0 1 0 0 0 3  000 000 a 1 0 0
// Emergency blocks presses, door permit still follows power
000 020 1 0 1 1 0 3  000 000 a 1 1 0
// Door permits drop once a request launches
008 000 1 1 0 1 0 3  008 000 3 0 0 0
// Emergency during an outstanding request
0a0 001 0 0 0 1 1 4  0a0 001 0 0 0 0
// Leftover lights served after emergency clears
000 000 0 0 0 1 0 3  0a0 000 5 1 0 0
// Slow acknowledge from the car
200 002 0 0 0 1 0 14 200 002 9 1 0 0
// Own floor press again after the trip down
000 002 0 0 0 1 0 3  000 000 1 0 0 0
// End of steps
ffff
